/* src/pio_pkg.sv */
// package with pio bus widths, address map, table sizes and entry types.
package pio_pkg;

	// pio host bus.
	localparam int PIO_NBITS      = 32;
	localparam int PIO_ADDR_NBITS = 16;

	// block select field of the byte address.
	localparam int BLK_MSB = 15;
	localparam int BLK_LSB = 12;

	localparam logic [BLK_MSB-BLK_LSB:0] BLK_TBL_A = 4'd0; // table a block.
	localparam logic [BLK_MSB-BLK_LSB:0] BLK_TBL_B = 4'd1; // table b block.

	// word index, address bits 11..2.
	localparam int IDX_NBITS = 10;

	// table depths as address widths.
	localparam int TBL_A_DEPTH_NBITS = 10; // 1024 entries.
	localparam int TBL_B_DEPTH_NBITS = 8;  // 256 entries.

	// entry payloads.
	typedef logic [19:0] tbl_a_t;
	typedef logic [11:0] tbl_b_t;

	// read data for an unmapped block.
	localparam logic [PIO_NBITS-1:0] PIO_BAD_DATA = 32'hbadadd00;

endpackage

/* src/ram_1r1w.sv */
// simple dual-port ram, one write port and one registered read port.
`timescale 1ns/1ps

module ram_1r1w #(
	parameter type data_t = logic [31:0],
	parameter int DEPTH_NBITS = 8
) (
	input  logic                   clk,
	input  logic                   wr,
	input  logic [DEPTH_NBITS-1:0] waddr,
	input  logic [DEPTH_NBITS-1:0] raddr,
	input  data_t                  din,
	output data_t                  dout
);

	localparam int DEPTH = 1 << DEPTH_NBITS;

	data_t mem [DEPTH]; // entry storage.

	// write port.
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din;
		end
	end

	// read port, one cycle latency.
	// old data on a same-address read and write.
	always_ff @(posedge clk) begin
		dout <= mem[raddr];
	end

endmodule

/* src/pio_decode.sv */
// pio access register and address decoder for the table blocks.
`timescale 1ns/1ps

module pio_decode (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               pio_rd,
	input  logic                               pio_wr,
	input  logic [pio_pkg::PIO_ADDR_NBITS-1:0] pio_addr,
	input  logic [pio_pkg::PIO_NBITS-1:0]      pio_din,
	output logic                               rd,
	output logic                               wr,
	output logic [pio_pkg::IDX_NBITS-1:0]      idx,
	output logic [pio_pkg::PIO_NBITS-1:0]      din,
	output logic                               ms_a,
	output logic                               ms_b,
	output logic                               ms_bad
);

	logic                                         acc;   // any host strobe.
	logic [pio_pkg::BLK_MSB-pio_pkg::BLK_LSB:0]   blk;   // block field.
	logic                                         hit_a;
	logic                                         hit_b;

	assign acc   = pio_rd | pio_wr;
	assign blk   = pio_addr[pio_pkg::BLK_MSB:pio_pkg::BLK_LSB];
	assign hit_a = (blk == pio_pkg::BLK_TBL_A);
	assign hit_b = (blk == pio_pkg::BLK_TBL_B);

	// strobes and selects, one cycle each.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd     <= 1'b0;
			wr     <= 1'b0;
			ms_a   <= 1'b0;
			ms_b   <= 1'b0;
			ms_bad <= 1'b0;
		end else begin
			rd     <= pio_rd;
			wr     <= pio_wr;
			ms_a   <= acc & hit_a;
			ms_b   <= acc & hit_b;
			ms_bad <= acc & ~hit_a & ~hit_b; // nothing mapped there.
		end
	end

	// index and data held until the next access.
	// a saved table read reuses idx later.
	always_ff @(posedge clk) begin
		if (acc) begin
			idx <= pio_addr[2 +: pio_pkg::IDX_NBITS]; // dword index.
			din <= pio_din;
		end
	end

endmodule

/* src/pio_mem.sv */
// pio accessible table memory with app read priority and clk_div paced ack.
`timescale 1ns/1ps

module pio_mem #(
	parameter type data_t = pio_pkg::tbl_a_t,
	parameter int DEPTH_NBITS = 10
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          clk_div,
	input  logic                          ms,
	input  logic                          rd,
	input  logic                          wr,
	input  logic [pio_pkg::IDX_NBITS-1:0] idx,
	input  logic [pio_pkg::PIO_NBITS-1:0] din,
	input  logic                          app_rd,
	input  logic [DEPTH_NBITS-1:0]        app_raddr,
	output logic                          mem_ack,
	output logic [pio_pkg::PIO_NBITS-1:0] mem_rdata,
	output logic                          app_ack,
	output data_t                         app_rdata
);

	localparam int DATA_NBITS = $bits(data_t);

	logic                   ram_wr;
	logic                   ram_rd;         // pio read this cycle.
	logic                   pio_rd_go;      // pio read owns the ram port.
	logic                   pio_rd_go_d1;   // its data is on ram_dout.
	logic                   rd_save;        // pio read blocked by the app.
	logic                   ack_pend;       // waiting for clk_div.
	logic [DEPTH_NBITS-1:0] ram_raddr;
	logic [DEPTH_NBITS-1:0] ram_waddr;
	data_t                  ram_wdata;
	data_t                  ram_dout;
	logic                   app_rd_d1;
	logic                   app_rd_d2;
	logic                   app_rd_d3;
	logic [DEPTH_NBITS-1:0] app_raddr_d1;
	data_t                  app_dout_d1;

	assign ram_wr    = ms & wr;
	assign ram_rd    = ms & rd;
	assign pio_rd_go = ~app_rd_d1 & (ram_rd | rd_save); // app wins the port.

	assign ram_waddr = idx[DEPTH_NBITS-1:0];           // low index bits only.
	assign ram_wdata = data_t'(din[DATA_NBITS-1:0]);   // truncate to entry.
	assign ram_raddr = app_rd_d1 ? app_raddr_d1 : idx[DEPTH_NBITS-1:0];

	ram_1r1w #(
		.data_t      (data_t),
		.DEPTH_NBITS (DEPTH_NBITS)
	) i_ram_1r1w (
		.clk   (clk),
		.wr    (ram_wr),
		.waddr (ram_waddr),
		.raddr (ram_raddr),
		.din   (ram_wdata),
		.dout  (ram_dout)
	);

	// app pipe, three stages to app_ack.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			app_rd_d1 <= 1'b0;
			app_rd_d2 <= 1'b0;
			app_rd_d3 <= 1'b0;
			app_ack   <= 1'b0;
		end else begin
			app_rd_d1 <= app_rd;
			app_rd_d2 <= app_rd_d1;  // ram_dout valid.
			app_rd_d3 <= app_rd_d2;
			app_ack   <= app_rd_d3;
		end
	end

	always_ff @(posedge clk) begin
		app_raddr_d1 <= app_raddr;
		app_dout_d1  <= ram_dout;
		app_rdata    <= app_dout_d1;
	end

	// pio side control.
	// a blocked read retries each cycle the app leaves free.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_save      <= 1'b0;
			pio_rd_go_d1 <= 1'b0;
			ack_pend     <= 1'b0;
			mem_ack      <= 1'b0;
		end else begin
			rd_save      <= app_rd_d1 & (ram_rd | rd_save); // cleared once served.
			pio_rd_go_d1 <= pio_rd_go;
			if (ram_wr | pio_rd_go_d1) begin
				ack_pend <= 1'b1;
			end else if (clk_div & ~mem_ack) begin
				ack_pend <= 1'b0; // handed to mem_ack.
			end
			if (clk_div) begin
				mem_ack <= ~mem_ack & ack_pend; // high for one clk_div period.
			end
		end
	end

	// read data for the host, zero extended.
	always_ff @(posedge clk) begin
		if (pio_rd_go_d1) begin
			mem_rdata <= {{(pio_pkg::PIO_NBITS-DATA_NBITS){1'b0}}, ram_dout};
		end
	end

endmodule

/* src/pio_resp.sv */
// pio response collector, ack pulse and read data mux, unmapped access ack.
`timescale 1ns/1ps

module pio_resp (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          clk_div,
	input  logic                          ms_bad,
	input  logic                          ack_a,
	input  logic [pio_pkg::PIO_NBITS-1:0] rdata_a,
	input  logic                          ack_b,
	input  logic [pio_pkg::PIO_NBITS-1:0] rdata_b,
	output logic                          pio_ack,
	output logic [pio_pkg::PIO_NBITS-1:0] pio_rdata
);

	logic       bad_pend;   // unmapped access waiting for clk_div.
	logic       bad_ack;    // level, like a table mem_ack.
	logic [2:0] ack_lvl;    // {bad, b, a}.
	logic [2:0] ack_lvl_d1;
	logic [2:0] ack_rise;

	assign ack_lvl  = {bad_ack, ack_b, ack_a};
	assign ack_rise = ack_lvl & ~ack_lvl_d1; // one cycle per ack.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bad_pend   <= 1'b0;
			bad_ack    <= 1'b0;
			ack_lvl_d1 <= 3'b000;
			pio_ack    <= 1'b0;
		end else begin
			if (ms_bad) begin
				bad_pend <= 1'b1;
			end else if (clk_div & ~bad_ack) begin
				bad_pend <= 1'b0;
			end
			if (clk_div) begin
				bad_ack <= ~bad_ack & bad_pend; // same pacing as the tables.
			end
			ack_lvl_d1 <= ack_lvl;
			pio_ack    <= |ack_rise;
		end
	end

	// data from whichever source just acked.
	always_ff @(posedge clk) begin
		if (ack_rise[0]) begin
			pio_rdata <= rdata_a;
		end else if (ack_rise[1]) begin
			pio_rdata <= rdata_b;
		end else if (ack_rise[2]) begin
			pio_rdata <= pio_pkg::PIO_BAD_DATA; // unmapped.
		end
	end

endmodule

/* src/pio_mem_subsys.sv */
// top level, pio decoder, two table memories and response collector.
`timescale 1ns/1ps

module pio_mem_subsys (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  clk_div,
	input  logic [pio_pkg::PIO_ADDR_NBITS-1:0]    pio_addr,
	input  logic [pio_pkg::PIO_NBITS-1:0]         pio_din,
	input  logic                                  pio_rd,
	input  logic                                  pio_wr,
	output logic                                  pio_ack,
	output logic [pio_pkg::PIO_NBITS-1:0]         pio_rdata,
	input  logic                                  app_a_rd,
	input  logic [pio_pkg::TBL_A_DEPTH_NBITS-1:0] app_a_raddr,
	output logic                                  app_a_ack,
	output pio_pkg::tbl_a_t                       app_a_rdata,
	input  logic                                  app_b_rd,
	input  logic [pio_pkg::TBL_B_DEPTH_NBITS-1:0] app_b_raddr,
	output logic                                  app_b_ack,
	output pio_pkg::tbl_b_t                       app_b_rdata
);

	logic                          rd;
	logic                          wr;
	logic [pio_pkg::IDX_NBITS-1:0] idx;  // shared by both tables.
	logic [pio_pkg::PIO_NBITS-1:0] din;
	logic                          ms_a;
	logic                          ms_b;
	logic                          ms_bad;
	logic                          ack_a;
	logic                          ack_b;
	logic [pio_pkg::PIO_NBITS-1:0] rdata_a;
	logic [pio_pkg::PIO_NBITS-1:0] rdata_b;

	pio_decode i_pio_decode (
		.clk (clk), .rst_n (rst_n),
		.pio_rd (pio_rd), .pio_wr (pio_wr), .pio_addr (pio_addr), .pio_din (pio_din),
		.rd (rd), .wr (wr), .idx (idx), .din (din),
		.ms_a (ms_a), .ms_b (ms_b), .ms_bad (ms_bad)
	);

	// table a, 20-bit entries.
	pio_mem #(.data_t (pio_pkg::tbl_a_t), .DEPTH_NBITS (pio_pkg::TBL_A_DEPTH_NBITS)) i_tbl_a (
		.clk (clk), .rst_n (rst_n), .clk_div (clk_div),
		.ms (ms_a), .rd (rd), .wr (wr), .idx (idx), .din (din),
		.app_rd (app_a_rd), .app_raddr (app_a_raddr),
		.mem_ack (ack_a), .mem_rdata (rdata_a),
		.app_ack (app_a_ack), .app_rdata (app_a_rdata)
	);

	// table b, 12-bit entries.
	pio_mem #(.data_t (pio_pkg::tbl_b_t), .DEPTH_NBITS (pio_pkg::TBL_B_DEPTH_NBITS)) i_tbl_b (
		.clk (clk), .rst_n (rst_n), .clk_div (clk_div),
		.ms (ms_b), .rd (rd), .wr (wr), .idx (idx), .din (din),
		.app_rd (app_b_rd), .app_raddr (app_b_raddr),
		.mem_ack (ack_b), .mem_rdata (rdata_b),
		.app_ack (app_b_ack), .app_rdata (app_b_rdata)
	);

	pio_resp i_pio_resp (
		.clk (clk), .rst_n (rst_n), .clk_div (clk_div),
		.ms_bad (ms_bad),
		.ack_a (ack_a), .rdata_a (rdata_a),
		.ack_b (ack_b), .rdata_b (rdata_b),
		.pio_ack (pio_ack), .pio_rdata (pio_rdata)
	);

endmodule

/* sim/tb_pio_mem_subsys.sv */
// testbench for the pio memory subsystem, directed tests against table models.
`timescale 1ns/1ps

module tb_pio_mem_subsys;

	localparam int NW = 8; // entries written per table.

	logic                                  clk;
	logic                                  rst_n;
	logic                                  clk_div;
	logic [pio_pkg::PIO_ADDR_NBITS-1:0]    pio_addr;
	logic [pio_pkg::PIO_NBITS-1:0]         pio_din;
	logic                                  pio_rd;
	logic                                  pio_wr;
	logic                                  pio_ack;
	logic [pio_pkg::PIO_NBITS-1:0]         pio_rdata;
	logic                                  app_a_rd;
	logic [pio_pkg::TBL_A_DEPTH_NBITS-1:0] app_a_raddr;
	logic                                  app_a_ack;
	pio_pkg::tbl_a_t                       app_a_rdata;
	logic                                  app_b_rd;
	logic [pio_pkg::TBL_B_DEPTH_NBITS-1:0] app_b_raddr;
	logic                                  app_b_ack;
	pio_pkg::tbl_b_t                       app_b_rdata;

	logic [19:0] model_a [1024]; // table a model.
	logic [11:0] model_b [256];  // table b model.
	logic [9:0]  idx_a [NW];
	logic [7:0]  idx_b [NW];
	logic [1:0]  div_cnt;
	int          errors;
	int          seed;
	int          cyc_cnt;
	int          ack_cyc;     // cycle of the last pio_ack.
	int          app_end_cyc; // cycle of the last app request.

	pio_mem_subsys i_pio_mem_subsys (.*);

	always #4 clk = ~clk; // 8 ns period.

	always @(posedge clk) begin
		cyc_cnt <= cyc_cnt + 1;
	end

	// clk_div, one cycle in four.
	always @(posedge clk) begin
		#1;
		div_cnt = div_cnt + 2'd1;
		clk_div = (div_cnt == 2'd0);
	end

	function automatic logic [15:0] addr_a(input logic [9:0] i);
		return {4'd0, i, 2'b00}; // block 0.
	endfunction

	function automatic logic [15:0] addr_b(input logic [7:0] i);
		return {4'd1, 2'b00, i, 2'b00}; // block 1.
	endfunction

	// waits for one pio_ack pulse, then one cycle to see it drop.
	task automatic wait_ack(input string name, output logic got, output logic [31:0] rdata);
		int cyc;
		got = 1'b0;
		rdata = '0;
		cyc = 0;
		while (!got && cyc < 64) begin
			@(negedge clk);
			if (pio_ack) begin
				got = 1'b1;
				rdata = pio_rdata; // valid with the ack.
				ack_cyc = cyc_cnt;
			end
			cyc++;
		end
		if (!got) begin
			$display("%s: no pio_ack within 64 cycles", name);
			errors++;
		end
		@(posedge clk);
		#1;
		if (got && pio_ack !== 1'b0) begin
			$display("%s: pio_ack stayed high for more than one cycle", name);
			errors++;
		end
	endtask

	task automatic pio_write(input string name, input logic [15:0] addr, input logic [31:0] data);
		logic        got;
		logic [31:0] rdata;
		pio_addr = addr;
		pio_din = data;
		pio_wr = 1'b1;
		@(posedge clk);
		#1;
		pio_wr = 1'b0; // one cycle strobe.
		wait_ack(name, got, rdata);
	endtask

	task automatic pio_read(input string name, input logic [15:0] addr, input logic [31:0] exp);
		logic        got;
		logic [31:0] rdata;
		pio_addr = addr;
		pio_rd = 1'b1;
		@(posedge clk);
		#1;
		pio_rd = 1'b0;
		wait_ack(name, got, rdata);
		if (got && rdata !== exp) begin
			$display("ERR %s: expected %h, actual %h", name, exp, rdata);
			errors++;
		end
	endtask

	// back to back app reads, ack checked 3 cycles after each request.
	task automatic app_read_burst(input string name, input int n, input bit do_b);
		logic [9:0] ra [32];
		logic [7:0] rb [32];
		int         j;
		for (int k = 0; k < n + 4; k++) begin
			if (k < n) begin
				ra[k] = idx_a[k % NW];
				rb[k] = idx_b[(k + 3) % NW];
				app_a_rd = 1'b1;
				app_a_raddr = ra[k];
				app_b_rd = do_b;
				app_b_raddr = rb[k];
				app_end_cyc = cyc_cnt;
			end else begin
				app_a_rd = 1'b0;
				app_b_rd = 1'b0;
			end
			@(negedge clk);
			j = k - 4; // request sampled at edge j+1, acked at edge j+4.
			if (app_a_ack !== (j >= 0)) begin
				$display("ERR %s app_a_ack: expected %b, actual %b", name, j >= 0, app_a_ack);
				errors++;
			end else if (j >= 0) begin
				if (app_a_rdata !== model_a[ra[j]]) begin
					$display("ERR %s a: expected %h, actual %h", name, model_a[ra[j]], app_a_rdata);
					errors++;
				end
			end
			if (app_b_ack !== (do_b && j >= 0)) begin
				$display("ERR %s app_b_ack: expected %b, actual %b", name, do_b && j >= 0, app_b_ack);
				errors++;
			end else if (do_b && j >= 0) begin
				if (app_b_rdata !== model_b[rb[j]]) begin
					$display("ERR %s b: expected %h, actual %h", name, model_b[rb[j]], app_b_rdata);
					errors++;
				end
			end
			@(posedge clk);
			#1;
		end
	endtask

	task automatic check_tables(input string name);
		for (int k = 0; k < NW; k++) begin
			pio_read({name, "_a"}, addr_a(idx_a[k]), {12'h000, model_a[idx_a[k]]});
			pio_read({name, "_b"}, addr_b(idx_b[k]), {20'h00000, model_b[idx_b[k]]});
		end
	endtask

	task automatic reset_check();
		if (pio_ack !== 1'b0 || app_a_ack !== 1'b0 || app_b_ack !== 1'b0) begin
			$display("ERR reset acks: expected 000, actual %b%b%b", pio_ack, app_a_ack, app_b_ack);
			errors++;
		end
	endtask

	task automatic write_readback();
		logic [31:0] rnd;
		logic [31:0] data;
		for (int k = 0; k < NW; k++) begin
			rnd = $random(seed);
			data = $random(seed);
			idx_a[k] = rnd[9:0];
			model_a[idx_a[k]] = data[19:0]; // truncated to entry width.
			pio_write("wr_a", addr_a(idx_a[k]), data);
			rnd = $random(seed);
			data = $random(seed);
			idx_b[k] = rnd[7:0];
			model_b[idx_b[k]] = data[11:0];
			pio_write("wr_b", addr_b(idx_b[k]), data);
		end
		check_tables("readback");
	endtask

	// pio read of table a during a 10 cycle app burst.
	task automatic collision();
		fork
			app_read_burst("collide_app", 10, 1'b0);
			begin
				repeat (2) @(posedge clk);
				#1;
				pio_read("collide_pio", addr_a(idx_a[1]), {12'h000, model_a[idx_a[1]]});
			end
		join
		if (ack_cyc <= app_end_cyc + 1) begin
			$display("collide_pio: pio read acked before the app burst ended");
			errors++;
		end
	endtask

	task automatic unmapped();
		pio_read("bad_rd", {4'd5, 12'h040}, 32'hbadadd00);
		// indices alias written entries of table a and of table b.
		pio_write("bad_wr_a", {4'd5, idx_a[0], 2'b00}, 32'hffffffff);
		pio_write("bad_wr_b", {4'd5, 2'b00, idx_b[0], 2'b00}, 32'hffffffff); // no table hit.
		check_tables("after_bad");
	endtask

	initial begin
		seed = 28;
		errors = 0;
		cyc_cnt = 0;
		ack_cyc = 0;
		app_end_cyc = 0;
		div_cnt = 2'd0;
		clk = 1'b0;
		rst_n = 1'b0;
		clk_div = 1'b0;
		pio_addr = '0;
		pio_din = '0;
		pio_rd = 1'b0;
		pio_wr = 1'b0;
		app_a_rd = 1'b0;
		app_a_raddr = '0;
		app_b_rd = 1'b0;
		app_b_raddr = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		reset_check();
		write_readback();
		app_read_burst("app_burst", 16, 1'b1);
		collision();
		unmapped();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* project.f */
src/pio_pkg.sv
src/ram_1r1w.sv
src/pio_decode.sv
src/pio_mem.sv
src/pio_resp.sv
src/pio_mem_subsys.sv
sim/tb_pio_mem_subsys.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then check the log for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tb_pio_mem_subsys \
	-f project.f -o tb_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim 2>&1 | tee sim.log
grep -qx "Done: no errors" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
